// ==== soc_pkg.sv ====
package soc_pkg;

	localparam int imem_addr_w = 8;
	localparam int dmem_addr_w = 8;
	localparam int imem_depth = 256;
	localparam int dmem_depth = 256;

	// serial bit period in clocks
	localparam int clks_per_bit = 8;
	localparam int bit_div_w = $clog2(clks_per_bit);

	typedef logic [31:0] word_t;

	typedef struct packed {
		logic valid;
		logic [7:0] data;
	} byte_stream_t;

	typedef struct packed {
		logic [imem_addr_w-1:0] addr;
		word_t data;
		logic valid;
	} imem_wr_t;

	typedef enum logic [3:0] {
		op_li,
		op_add,
		op_sub,
		op_lw,
		op_sw,
		op_out,
		op_bnz,
		op_halt
	} opcode_t;

	typedef struct packed {
		opcode_t opcode;
		logic [2:0] rd;
		logic [2:0] rs1;
		logic [2:0] rs2;
		logic [18:0] unused;
	} inst_r_t;

	// imm shares its bits with the unused tail of the register form
	typedef struct packed {
		opcode_t opcode;
		logic [2:0] rd;
		logic [2:0] rs1;
		logic [5:0] unused;
		logic [15:0] imm;
	} inst_i_t;

	typedef union packed {
		inst_r_t r;
		inst_i_t i;
	} inst_t;

endpackage

// ==== uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx (
	input logic clk,
	input logic rst_n,
	input logic rx,
	output soc_pkg::byte_stream_t rx_byte
);

	typedef enum logic [1:0] {s_idle, s_start, s_data, s_stop} state_t;

	state_t state;
	logic [1:0] sync;
	logic rx_s;
	logic [soc_pkg::bit_div_w-1:0] div;
	logic [2:0] bit_cnt;
	logic [7:0] shift;
	logic sample;

	assign rx_s = sync[1];
	assign sample = (state == s_data) && (div == soc_pkg::clks_per_bit - 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync <= 2'b11;
			state <= s_idle;
			div <= '0;
			bit_cnt <= '0;
			rx_byte <= '0;
		end else begin
			sync <= {sync[0], rx};
			rx_byte.valid <= 1'b0;
			case (state)
				s_idle: begin
					div <= '0;
					if (!rx_s)
						state <= s_start;
				end
				s_start: begin
					// recheck at mid start bit, drop glitches
					if (div == soc_pkg::clks_per_bit / 2 - 1) begin
						div <= '0;
						bit_cnt <= '0;
						state <= rx_s ? s_idle : s_data;
					end else begin
						div <= div + 1'b1;
					end
				end
				s_data: begin
					if (sample) begin
						div <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= s_stop;
					end else begin
						div <= div + 1'b1;
					end
				end
				s_stop: begin
					if (div == soc_pkg::clks_per_bit - 1) begin
						div <= '0;
						state <= s_idle;
						// bad stop bit, frame dropped
						if (rx_s) begin
							rx_byte.valid <= 1'b1;
							rx_byte.data <= shift;
						end
					end else begin
						div <= div + 1'b1;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// lsb first
	always_ff @(posedge clk) begin
		if (sample)
			shift <= {rx_s, shift[7:1]};
	end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx (
	input logic clk,
	input logic rst_n,
	input soc_pkg::byte_stream_t tx_byte,
	output logic tx_ready,
	output logic tx
);

	logic busy;
	logic [9:0] frame;
	logic [3:0] bit_cnt;
	logic [soc_pkg::bit_div_w-1:0] div;

	assign tx_ready = !busy;
	// frame shifts ones in behind it, so the line rests high
	assign tx = frame[0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			frame <= '1;
			bit_cnt <= '0;
			div <= '0;
		end else if (!busy) begin
			if (tx_byte.valid) begin
				// stop, data, start
				frame <= {1'b1, tx_byte.data, 1'b0};
				busy <= 1'b1;
				bit_cnt <= '0;
				div <= '0;
			end
		end else begin
			if (div == soc_pkg::clks_per_bit - 1) begin
				div <= '0;
				frame <= {1'b1, frame[9:1]};
				if (bit_cnt == 4'd9)
					busy <= 1'b0;
				else
					bit_cnt <= bit_cnt + 1'b1;
			end else begin
				div <= div + 1'b1;
			end
		end
	end

endmodule

// ==== program_loader.sv ====
`timescale 1ns/100ps

module program_loader (
	input logic clk,
	input logic rst_n,
	input soc_pkg::byte_stream_t rx_byte,
	output soc_pkg::imem_wr_t imem_wr,
	input logic imem_wr_ready,
	output logic loaded
);

	typedef enum logic [1:0] {s_count, s_data, s_write, s_done} state_t;

	state_t state;
	logic [7:0] count;
	logic [soc_pkg::imem_addr_w-1:0] word_cnt;
	logic [1:0] byte_pos;
	soc_pkg::word_t word;

	always_comb begin
		imem_wr.valid = (state == s_write);
		imem_wr.addr = word_cnt;
		imem_wr.data = word;
	end

	assign loaded = (state == s_done);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_count;
			count <= '0;
			word_cnt <= '0;
			byte_pos <= '0;
		end else begin
			case (state)
				s_count: begin
					// a zero count is not a program
					if (rx_byte.valid && rx_byte.data != 8'd0) begin
						count <= rx_byte.data;
						word_cnt <= '0;
						byte_pos <= '0;
						state <= s_data;
					end
				end
				s_data: begin
					if (rx_byte.valid) begin
						byte_pos <= byte_pos + 1'b1;
						if (byte_pos == 2'd3)
							state <= s_write;
					end
				end
				s_write: begin
					if (imem_wr_ready) begin
						word_cnt <= word_cnt + 1'b1;
						if (word_cnt == count - 8'd1)
							state <= s_done;
						else
							state <= s_data;
					end
				end
				// stays here until rst_n, later bytes ignored
				s_done: state <= s_done;
				default: state <= s_count;
			endcase
		end
	end

	// little endian, first byte ends up in bits 7:0
	always_ff @(posedge clk) begin
		if (state == s_data && rx_byte.valid)
			word <= {rx_byte.data, word[31:8]};
	end

endmodule

// ==== inst_mem.sv ====
`timescale 1ns/100ps

module inst_mem (
	input logic clk,
	input logic rst_n,
	input soc_pkg::imem_wr_t imem_wr,
	output logic imem_wr_ready,
	input logic [soc_pkg::imem_addr_w-1:0] fetch_addr,
	output soc_pkg::word_t fetch_data
);

	soc_pkg::word_t mem [soc_pkg::imem_depth];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			imem_wr_ready <= 1'b0;
		else
			imem_wr_ready <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (imem_wr.valid && imem_wr_ready)
			mem[imem_wr.addr] <= imem_wr.data;
	end

	// registered read, one clock of latency
	always_ff @(posedge clk) begin
		fetch_data <= mem[fetch_addr];
	end

endmodule

// ==== data_mem.sv ====
`timescale 1ns/100ps

module data_mem (
	input logic clk,
	input logic rst_n,
	input logic [soc_pkg::dmem_addr_w-1:0] addr,
	input soc_pkg::word_t wdata,
	input logic we,
	output soc_pkg::word_t rdata
);

	soc_pkg::word_t mem [soc_pkg::dmem_depth];

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
	end

	// write first on the read side
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rdata <= '0;
		else if (we)
			rdata <= wdata;
		else
			rdata <= mem[addr];
	end

endmodule

// ==== core.sv ====
`timescale 1ns/100ps

module core (
	input logic clk,
	input logic rst_n,
	output logic [soc_pkg::imem_addr_w-1:0] fetch_addr,
	input soc_pkg::word_t fetch_data,
	output logic [soc_pkg::dmem_addr_w-1:0] dmem_addr,
	output soc_pkg::word_t dmem_wdata,
	output logic dmem_we,
	input soc_pkg::word_t dmem_rdata,
	output soc_pkg::byte_stream_t tx_byte,
	input logic tx_ready,
	output logic halted
);

	typedef enum logic [1:0] {s_fetch, s_exec, s_mem, s_out} state_t;

	state_t state;
	logic [soc_pkg::imem_addr_w-1:0] pc;
	soc_pkg::word_t regs [8];
	soc_pkg::inst_t inst;
	soc_pkg::opcode_t op;
	soc_pkg::word_t rs1_val;
	soc_pkg::word_t rs2_val;
	soc_pkg::word_t imm_val;
	logic rf_we;
	soc_pkg::word_t rf_wdata;

	// fetch_data stays on the current pc until pc moves
	always_comb begin
		inst = fetch_data;
		op = inst.r.opcode;
		rs1_val = (inst.r.rs1 == 3'd0) ? '0 : regs[inst.r.rs1];
		rs2_val = (inst.r.rs2 == 3'd0) ? '0 : regs[inst.r.rs2];
		imm_val = {16'h0000, inst.i.imm};
	end

	assign fetch_addr = pc;
	assign dmem_addr = inst.i.imm[soc_pkg::dmem_addr_w-1:0];
	assign dmem_wdata = rs1_val;
	assign dmem_we = (state == s_exec) && (op == soc_pkg::op_sw);

	always_comb begin
		tx_byte.valid = ((state == s_exec) && (op == soc_pkg::op_out)) || (state == s_out);
		tx_byte.data = rs1_val[7:0];
	end

	always_comb begin
		rf_we = 1'b0;
		rf_wdata = '0;
		if (state == s_exec) begin
			case (op)
				soc_pkg::op_li: begin
					rf_we = 1'b1;
					rf_wdata = imm_val;
				end
				soc_pkg::op_add: begin
					rf_we = 1'b1;
					rf_wdata = rs1_val + rs2_val;
				end
				soc_pkg::op_sub: begin
					rf_we = 1'b1;
					rf_wdata = rs1_val - rs2_val;
				end
				default: rf_we = 1'b0;
			endcase
		end else if (state == s_mem) begin
			rf_we = 1'b1;
			rf_wdata = dmem_rdata;
		end
	end

	// r0 is never written
	always_ff @(posedge clk) begin
		if (rf_we && inst.r.rd != 3'd0)
			regs[inst.r.rd] <= rf_wdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_fetch;
			pc <= '0;
			halted <= 1'b0;
		end else begin
			case (state)
				s_fetch: begin
					if (!halted)
						state <= s_exec;
				end
				s_exec: begin
					state <= s_fetch;
					case (op)
						soc_pkg::op_lw: state <= s_mem;
						soc_pkg::op_out: begin
							if (tx_ready)
								pc <= pc + 1'b1;
							else
								state <= s_out;
						end
						soc_pkg::op_bnz: begin
							if (rs1_val != '0)
								pc <= imm_val[soc_pkg::imem_addr_w-1:0];
							else
								pc <= pc + 1'b1;
						end
						soc_pkg::op_halt: halted <= 1'b1;
						default: pc <= pc + 1'b1;
					endcase
				end
				s_mem: begin
					pc <= pc + 1'b1;
					state <= s_fetch;
				end
				s_out: begin
					// stall until the transmitter takes the byte
					if (tx_ready) begin
						pc <= pc + 1'b1;
						state <= s_fetch;
					end
				end
				default: state <= s_fetch;
			endcase
		end
	end

endmodule

// ==== chip.sv ====
`timescale 1ns/100ps

module chip (
	input logic clk,
	input logic rst_n,
	input logic uart_rx,
	output logic uart_tx,
	output logic loaded,
	output logic halted
);

	soc_pkg::byte_stream_t rx_byte;
	soc_pkg::byte_stream_t tx_byte;
	logic tx_ready;
	soc_pkg::imem_wr_t imem_wr;
	logic imem_wr_ready;
	logic [soc_pkg::imem_addr_w-1:0] fetch_addr;
	soc_pkg::word_t fetch_data;
	logic [soc_pkg::dmem_addr_w-1:0] dmem_addr;
	soc_pkg::word_t dmem_wdata;
	soc_pkg::word_t dmem_rdata;
	logic dmem_we;
	logic core_rst_n;

	// core and data memory wait for the loader
	assign core_rst_n = rst_n & loaded;

	uart_rx rx0 (
		.clk(clk),
		.rst_n(rst_n),
		.rx(uart_rx),
		.rx_byte(rx_byte)
	);

	uart_tx tx0 (
		.clk(clk),
		.rst_n(rst_n),
		.tx_byte(tx_byte),
		.tx_ready(tx_ready),
		.tx(uart_tx)
	);

	program_loader loader0 (
		.clk(clk),
		.rst_n(rst_n),
		.rx_byte(rx_byte),
		.imem_wr(imem_wr),
		.imem_wr_ready(imem_wr_ready),
		.loaded(loaded)
	);

	inst_mem imem0 (
		.clk(clk),
		.rst_n(rst_n),
		.imem_wr(imem_wr),
		.imem_wr_ready(imem_wr_ready),
		.fetch_addr(fetch_addr),
		.fetch_data(fetch_data)
	);

	data_mem dmem0 (
		.clk(clk),
		.rst_n(core_rst_n),
		.addr(dmem_addr),
		.wdata(dmem_wdata),
		.we(dmem_we),
		.rdata(dmem_rdata)
	);

	core core0 (
		.clk(clk),
		.rst_n(core_rst_n),
		.fetch_addr(fetch_addr),
		.fetch_data(fetch_data),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_we(dmem_we),
		.dmem_rdata(dmem_rdata),
		.tx_byte(tx_byte),
		.tx_ready(tx_ready),
		.halted(halted)
	);

endmodule

// ==== tb_chip.sv ====
`timescale 1ns/100ps

module tb_chip;

	logic clk;
	logic rst_n;
	logic uart_rx;
	logic uart_tx;
	logic loaded;
	logic halted;

	int seed = 42647;
	int mismatches = 0;
	int timeouts = 0;
	int frame_errors = 0;
	int starts_seen = 0;
	logic [7:0] rx_q[$];
	logic [7:0] exp_q[$];
	logic [31:0] prog[$];

	chip dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.uart_rx(uart_rx),
		.uart_tx(uart_tx),
		.loaded(loaded),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] enc_reg(soc_pkg::opcode_t op, logic [2:0] rd,
			logic [2:0] rs1, logic [2:0] rs2);
		return {op, rd, rs1, rs2, 19'd0};
	endfunction

	// imm in the low half, zero extended by the core
	function automatic logic [31:0] enc_imm(soc_pkg::opcode_t op, logic [2:0] rd,
			logic [2:0] rs1, logic [15:0] imm);
		return {op, rd, rs1, 6'd0, imm};
	endfunction

	task automatic check_value(string test, string what, logic [31:0] expected,
			logic [31:0] actual);
		assert (actual === expected) else begin
			mismatches++;
			$display("Mismatch in %s (%s): expected %0d, actual %0d", test, what, expected, actual);
		end
	endtask

	// mid-bit sampling on falling edges
	task automatic decode_serial();
		logic [7:0] data;
		forever begin
			@(negedge clk);
			if (!uart_tx) begin
				starts_seen++;
				repeat (soc_pkg::clks_per_bit + soc_pkg::clks_per_bit / 2) @(negedge clk);
				for (int i = 0; i < 8; i++) begin
					data[i] = uart_tx;
					repeat (soc_pkg::clks_per_bit) @(negedge clk);
				end
				assert (uart_tx) else begin
					frame_errors++;
					$display("Output frame had a low stop bit");
				end
				rx_q.push_back(data);
			end
		end
	endtask

	initial decode_serial();

	task automatic send_byte(logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			uart_rx = frame[i];
			repeat (soc_pkg::clks_per_bit) @(negedge clk);
		end
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		uart_rx = 1'b1;
		repeat (16) @(negedge clk);
		rx_q.delete();
		exp_q.delete();
		prog.delete();
		starts_seen = 0;
		rst_n = 1'b1;
	endtask

	task automatic check_idle(string test);
		repeat (24) begin
			@(negedge clk);
			check_value(test, "uart_tx idle", 1, uart_tx);
			check_value(test, "loaded idle", 0, loaded);
			check_value(test, "halted idle", 0, halted);
		end
	endtask

	task automatic wait_loaded(string test);
		int n;
		n = 0;
		while (!loaded && n < 400) begin
			@(negedge clk);
			n++;
		end
		if (!loaded) begin
			timeouts++;
			$display("Timeout in %s: loaded never went high", test);
		end
	endtask

	task automatic wait_halted(string test);
		int n;
		n = 0;
		while (!halted && n < 5000) begin
			@(negedge clk);
			n++;
		end
		if (!halted) begin
			timeouts++;
			$display("Timeout in %s: core never halted", test);
		end
	endtask

	task automatic wait_bytes(string test, int count);
		int n;
		n = 0;
		while (rx_q.size() < count && n < 2000) begin
			@(negedge clk);
			n++;
		end
		if (rx_q.size() < count) begin
			timeouts++;
			$display("Timeout in %s: only %0d output bytes arrived", test, rx_q.size());
		end
	endtask

	task automatic load_program(string test);
		send_byte(8'(prog.size()));
		foreach (prog[w]) begin
			for (int k = 0; k < 4; k++) begin
				if (w == prog.size() - 1 && k == 3)
					check_value(test, "loaded before last byte", 0, loaded);
				send_byte(prog[w][8*k +: 8]);
			end
		end
		wait_loaded(test);
	endtask

	task automatic run_program(string test, int extra);
		load_program(test);
		for (int i = 0; i < extra; i++)
			send_byte(8'($random(seed)));
		wait_halted(test);
		check_value(test, "bytes started at halt", exp_q.size(), starts_seen);
		wait_bytes(test, exp_q.size());
		// a frame and more of silence catches stray output
		repeat (12 * soc_pkg::clks_per_bit) @(negedge clk);
		check_value(test, "byte count", exp_q.size(), rx_q.size());
		foreach (exp_q[i])
			if (i < rx_q.size())
				check_value(test, $sformatf("byte %0d", i), exp_q[i], rx_q[i]);
		check_value(test, "halted held", 1, halted);
	endtask

	initial begin
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] v;
		logic [31:0] res;
		int cnt;

		apply_reset();
		check_idle("reset_idle");

		apply_reset();
		for (int i = 1; i <= 3; i++) begin
			v = 16'($random(seed)) & 16'h00ff;
			prog.push_back(enc_imm(soc_pkg::op_li, 3'(i), 3'd0, v));
			prog.push_back(enc_imm(soc_pkg::op_out, 3'd0, 3'(i), 16'd0));
			exp_q.push_back(v[7:0]);
		end
		prog.push_back(enc_imm(soc_pkg::op_halt, 3'd0, 3'd0, 16'd0));
		run_program("imm_out", 0);

		apply_reset();
		check_idle("arith");
		a = 16'($random(seed));
		b = 16'($random(seed));
		prog.push_back(enc_imm(soc_pkg::op_li, 3'd1, 3'd0, a));
		prog.push_back(enc_imm(soc_pkg::op_li, 3'd2, 3'd0, b));
		prog.push_back(enc_reg(soc_pkg::op_add, 3'd3, 3'd1, 3'd2));
		prog.push_back(enc_imm(soc_pkg::op_out, 3'd0, 3'd3, 16'd0));
		prog.push_back(enc_reg(soc_pkg::op_sub, 3'd4, 3'd1, 3'd2));
		prog.push_back(enc_imm(soc_pkg::op_out, 3'd0, 3'd4, 16'd0));
		prog.push_back(enc_imm(soc_pkg::op_halt, 3'd0, 3'd0, 16'd0));
		res = {16'd0, a} + {16'd0, b};
		exp_q.push_back(res[7:0]);
		res = {16'd0, a} - {16'd0, b};
		exp_q.push_back(res[7:0]);
		run_program("arith", 0);

		apply_reset();
		check_idle("memory");
		v = 16'($random(seed));
		a = 16'($random(seed)) & 16'h00ff;
		prog.push_back(enc_imm(soc_pkg::op_li, 3'd1, 3'd0, v));
		prog.push_back(enc_imm(soc_pkg::op_sw, 3'd0, 3'd1, a));
		prog.push_back(enc_imm(soc_pkg::op_lw, 3'd5, 3'd0, a));
		prog.push_back(enc_imm(soc_pkg::op_out, 3'd0, 3'd5, 16'd0));
		prog.push_back(enc_imm(soc_pkg::op_halt, 3'd0, 3'd0, 16'd0));
		exp_q.push_back(v[7:0]);
		run_program("memory", 0);

		// back-to-back outputs stall the core in out-wait
		apply_reset();
		check_idle("countdown");
		cnt = 3 + (($random(seed) & 32'h7fffffff) % 8);
		prog.push_back(enc_imm(soc_pkg::op_li, 3'd1, 3'd0, 16'(cnt)));
		prog.push_back(enc_imm(soc_pkg::op_li, 3'd2, 3'd0, 16'd1));
		prog.push_back(enc_imm(soc_pkg::op_out, 3'd0, 3'd1, 16'd0));
		prog.push_back(enc_reg(soc_pkg::op_sub, 3'd1, 3'd1, 3'd2));
		prog.push_back(enc_imm(soc_pkg::op_bnz, 3'd0, 3'd1, 16'd2));
		prog.push_back(enc_imm(soc_pkg::op_halt, 3'd0, 3'd0, 16'd0));
		for (int i = cnt; i >= 1; i--)
			exp_q.push_back(8'(i));
		run_program("countdown", 0);

		apply_reset();
		check_idle("extra_bytes");
		v = 16'($random(seed)) & 16'h00ff;
		prog.push_back(enc_imm(soc_pkg::op_li, 3'd6, 3'd0, v));
		prog.push_back(enc_imm(soc_pkg::op_out, 3'd0, 3'd6, 16'd0));
		prog.push_back(enc_imm(soc_pkg::op_halt, 3'd0, 3'd0, 16'd0));
		exp_q.push_back(v[7:0]);
		run_program("extra_bytes", 3);

		$display("errors: %0d mismatches, %0d timeouts, %0d framing", mismatches, timeouts,
			frame_errors);
		if (mismatches + timeouts + frame_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== chip.f ====
soc_pkg.sv
uart_rx.sv
uart_tx.sv
program_loader.sv
inst_mem.sv
data_mem.sv
core.sv
chip.sv
tb_chip.sv

// ==== Bender.yml ====
package:
  name: chip

sources:
  - soc_pkg.sv
  - uart_rx.sv
  - uart_tx.sv
  - program_loader.sv
  - inst_mem.sv
  - data_mem.sv
  - core.sv
  - chip.sv
  - target: simulation
    files:
      - tb_chip.sv
